// ==== hdl/alu.sv ====
`default_nettype none

module alu
    import rv_pkg::*;
(
    input  wire  [31:0] a,
    input  wire  [31:0] b,
    input  wire alu_op_e op,
    output logic [31:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_sll:  y = a << shamt;
            alu_slt:  y = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: y = {31'd0, a < b};
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = $unsigned($signed(a) >>> shamt);
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          hold,
    input  wire          bubble,
    input  wire          flush,
    input  wire if_id_t  if_id,
    input  wire mem_wb_t wb,
    output id_ex_t       id_ex
);

    id_ex_t      d;
    logic [31:0] regs [1:31];
    logic [31:0] instr;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]  funct3;
    logic        wr_en;

    assign instr  = if_id.instr;
    assign funct3 = instr[14:12];
    assign wr_en  = wb.valid && wb.reg_we && wb.rd != 5'd0;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? alu_sub : alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return alt ? alu_sra : alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // Write-first so writeback needs no extra forward here.
    function automatic logic [31:0] read_reg(input logic [4:0] a);
        if (a == 5'd0)
            return 32'd0;
        if (wr_en && wb.rd == a)
            return wb.wb_data;
        return regs[a];
    endfunction

    always_comb begin
        d               = '0;
        d.valid         = if_id.valid;
        d.pc            = if_id.pc;
        d.rs1           = instr[19:15];
        d.rs2           = instr[24:20];
        d.rd            = instr[11:7];
        d.alu_op        = alu_add;
        d.br_op         = br_none;
        d.mem_size      = mem_size_e'(funct3[1:0]);
        d.load_unsigned = funct3[2];
        d.wb_sel        = wb_alu;
        case (instr[6:0])
            op_lui: begin
                d.rs1     = 5'd0; // Adds the immediate to zero.
                d.use_imm = 1'b1;
                d.reg_we  = 1'b1;
                d.imm     = imm_u;
            end
            op_auipc: begin
                d.use_pc_a = 1'b1;
                d.use_imm  = 1'b1;
                d.reg_we   = 1'b1;
                d.imm      = imm_u;
            end
            op_jal: begin
                d.br_op    = br_jump;
                d.use_pc_a = 1'b1;
                d.use_imm  = 1'b1;
                d.reg_we   = 1'b1;
                d.wb_sel   = wb_pc4;
                d.imm      = imm_j;
            end
            op_jalr: begin
                d.br_op   = br_jump;
                d.is_jalr = 1'b1;
                d.use_imm = 1'b1;
                d.reg_we  = 1'b1;
                d.wb_sel  = wb_pc4;
                d.imm     = imm_i;
            end
            op_branch: begin
                d.imm = imm_b;
                case (funct3)
                    3'd0:    d.br_op = br_beq;
                    3'd1:    d.br_op = br_bne;
                    3'd4:    d.br_op = br_blt;
                    3'd5:    d.br_op = br_bge;
                    3'd6:    d.br_op = br_bltu;
                    3'd7:    d.br_op = br_bgeu;
                    default: d.br_op = br_none;
                endcase
            end
            op_load: begin
                d.mem_re  = 1'b1;
                d.use_imm = 1'b1;
                d.reg_we  = 1'b1;
                d.wb_sel  = wb_load;
                d.imm     = imm_i;
            end
            op_store: begin
                d.mem_we  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = imm_s;
            end
            op_imm: begin
                d.use_imm = 1'b1;
                d.reg_we  = 1'b1;
                d.imm     = imm_i;
                d.alu_op  = alu_decode(funct3, instr[30] && funct3 == 3'd5);
            end
            op_reg: begin
                d.reg_we = 1'b1;
                d.alu_op = alu_decode(funct3, instr[30]);
            end
            default: ; // FENCE and SYSTEM pass as no-ops.
        endcase
        d.rs1_data = read_reg(d.rs1);
        d.rs2_data = read_reg(d.rs2);
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            regs[wb.rd] <= wb.wb_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            id_ex.valid <= 1'b0;
        else if (flush || bubble)
            id_ex.valid <= 1'b0;
        else if (!hold)
            id_ex <= d;
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none

module execute_stage
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           hold,
    input  wire id_ex_t   id_ex,
    input  wire fwd_sel_e fwd_a,
    input  wire fwd_sel_e fwd_b,
    input  wire ex_mem_t  mem_fwd,
    input  wire mem_wb_t  wb_fwd,
    output logic          taken,
    output logic [31:0]   redirect_pc,
    output ex_mem_t       ex_mem
);

    logic [31:0] mem_val, a_fwd, b_fwd;
    logic [31:0] op_a, op_b, alu_y, target;
    logic        cond;

    function automatic logic [31:0] fwd_mux(
        input fwd_sel_e    sel,
        input logic [31:0] rf_val,
        input logic [31:0] mem_v,
        input logic [31:0] wb_v
    );
        case (sel)
            fwd_mem: return mem_v;
            fwd_wb:  return wb_v;
            default: return rf_val;
        endcase
    endfunction

    // A jump in memory stage links pc+4, not its ALU sum.
    assign mem_val = (mem_fwd.wb_sel == wb_pc4) ? mem_fwd.pc + 32'd4 : mem_fwd.alu_result;

    assign a_fwd = fwd_mux(fwd_a, id_ex.rs1_data, mem_val, wb_fwd.wb_data);
    assign b_fwd = fwd_mux(fwd_b, id_ex.rs2_data, mem_val, wb_fwd.wb_data);
    assign op_a  = id_ex.use_pc_a ? id_ex.pc : a_fwd;
    assign op_b  = id_ex.use_imm ? id_ex.imm : b_fwd;

    alu alu_i (
        .a  (op_a),
        .b  (op_b),
        .op (id_ex.alu_op),
        .y  (alu_y)
    );

    always_comb begin
        case (id_ex.br_op)
            br_beq:  cond = a_fwd == b_fwd;
            br_bne:  cond = a_fwd != b_fwd;
            br_blt:  cond = $signed(a_fwd) < $signed(b_fwd);
            br_bge:  cond = $signed(a_fwd) >= $signed(b_fwd);
            br_bltu: cond = a_fwd < b_fwd;
            br_bgeu: cond = a_fwd >= b_fwd;
            br_jump: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign target      = (id_ex.is_jalr ? a_fwd : id_ex.pc) + id_ex.imm;
    assign redirect_pc = {target[31:1], target[0] & ~id_ex.is_jalr};
    assign taken       = id_ex.valid & cond;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else if (!hold) begin
            ex_mem.valid         <= id_ex.valid;
            ex_mem.pc            <= id_ex.pc;
            ex_mem.alu_result    <= alu_y;
            ex_mem.store_data    <= b_fwd;
            ex_mem.rd            <= id_ex.rd;
            ex_mem.reg_we        <= id_ex.reg_we;
            ex_mem.mem_re        <= id_ex.mem_re;
            ex_mem.mem_we        <= id_ex.mem_we;
            ex_mem.mem_size      <= id_ex.mem_size;
            ex_mem.load_unsigned <= id_ex.load_unsigned;
            ex_mem.wb_sel        <= id_ex.wb_sel;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none

module fetch_stage
    import rv_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          hold,
    input  wire          flush,
    input  wire  [31:0]  redirect_pc,
    input  wire  [31:0]  imem_data,
    output logic [31:0]  imem_addr,
    output if_id_t       if_id
);

    logic [31:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= reset_pc;
            if_id.valid <= 1'b0;
        end else if (flush) begin
            pc          <= redirect_pc;
            if_id.valid <= 1'b0; // Drop wrong-path fetch.
        end else if (!hold) begin
            pc          <= pc + 32'd4;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem_data;
        end
    end

    // Redirects come from execute, so this also covers branch targets.
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`default_nettype none

module hazard_unit
    import rv_pkg::*;
(
    input  wire if_id_t  if_id,
    input  wire id_ex_t  id_ex,
    input  wire ex_mem_t ex_mem,
    input  wire mem_wb_t mem_wb,
    input  wire          taken,
    input  wire          dmem_ready,
    output logic         stall,
    output logic         load_stall,
    output logic         flush,
    output fwd_sel_e     fwd_a,
    output fwd_sel_e     fwd_b
);

    logic load_hit;

    // Memory stage is younger, so it wins over writeback.
    function automatic fwd_sel_e pick(input logic [4:0] rs);
        fwd_sel_e sel;
        sel = fwd_rf;
        if (mem_wb.valid && mem_wb.reg_we && mem_wb.rd != 5'd0 && mem_wb.rd == rs)
            sel = fwd_wb;
        if (ex_mem.valid && ex_mem.reg_we && ex_mem.rd != 5'd0 && ex_mem.rd == rs)
            sel = fwd_mem;
        return sel;
    endfunction

    assign load_hit = if_id.valid && id_ex.valid && id_ex.mem_re && id_ex.rd != 5'd0 &&
                      (id_ex.rd == if_id.instr[19:15] || id_ex.rd == if_id.instr[24:20]);

    // Memory wait freezes everything, so nothing else may act then.
    assign stall      = ~dmem_ready;
    assign load_stall = load_hit & ~stall;
    assign flush      = taken & ~stall;

    always_comb begin
        fwd_a = pick(id_ex.rs1);
        fwd_b = pick(id_ex.rs2);
    end

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`default_nettype none

module memory_stage
    import rv_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          hold,
    input  wire ex_mem_t ex_mem,
    input  wire  [31:0]  dmem_rdata,
    output logic [31:0]  dmem_addr,
    output logic [31:0]  dmem_wdata,
    output logic [3:0]   dmem_be,
    output logic         dmem_we,
    output mem_wb_t      mem_wb
);

    logic [31:0] lane, load_val, wb_data;
    logic [1:0]  ofs;
    logic        sx;

    assign dmem_addr = ex_mem.alu_result;
    assign dmem_we   = ex_mem.valid & ex_mem.mem_we;
    assign ofs       = ex_mem.alu_result[1:0];
    assign lane      = dmem_rdata >> {ofs, 3'b000};
    assign sx        = ~ex_mem.load_unsigned;

    always_comb begin
        case (ex_mem.mem_size)
            size_byte: begin
                dmem_wdata = {4{ex_mem.store_data[7:0]}};
                dmem_be    = 4'b0001 << ofs;
                load_val   = {{24{sx & lane[7]}}, lane[7:0]};
            end
            size_half: begin
                dmem_wdata = {2{ex_mem.store_data[15:0]}};
                dmem_be    = ofs[1] ? 4'b1100 : 4'b0011;
                load_val   = {{16{sx & lane[15]}}, lane[15:0]};
            end
            default: begin
                dmem_wdata = ex_mem.store_data;
                dmem_be    = 4'b1111;
                load_val   = dmem_rdata;
            end
        endcase
    end

    assign wb_data = ex_mem.mem_re ? load_val :
                     (ex_mem.wb_sel == wb_pc4) ? ex_mem.pc + 32'd4 : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else if (!hold) begin
            mem_wb.valid   <= ex_mem.valid;
            mem_wb.pc      <= ex_mem.pc;
            mem_wb.rd      <= ex_mem.reg_we ? ex_mem.rd : 5'd0; // Retire reports x0.
            mem_wb.reg_we  <= ex_mem.reg_we;
            mem_wb.wb_data <= wb_data;
        end
    end

    // Memory wait must keep the bus request steady.
    assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(dmem_we) && $stable(dmem_addr) && $stable(dmem_wdata) &&
                 $stable(dmem_be))
        else $error("dmem outputs changed during memory wait");

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    output logic [31:0]  imem_addr,
    input  wire  [31:0]  imem_data,
    output logic [31:0]  dmem_addr,
    output logic [31:0]  dmem_wdata,
    output logic [3:0]   dmem_be,
    output logic         dmem_we,
    input  wire  [31:0]  dmem_rdata,
    input  wire          dmem_ready,
    output logic         retire_valid,
    output logic [31:0]  retire_pc,
    output logic [4:0]   retire_rd,
    output logic [31:0]  retire_data
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;
    fwd_sel_e    fwd_a, fwd_b;
    logic [31:0] redirect_pc;
    logic        stall, load_stall, flush, taken, front_hold;

    assign front_hold   = stall | load_stall;
    assign retire_valid = mem_wb.valid & ~stall; // Held entry retires once.
    assign retire_pc    = mem_wb.pc;
    assign retire_rd    = mem_wb.rd;
    assign retire_data  = mem_wb.wb_data;

    fetch_stage fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (front_hold),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_id       (if_id)
    );

    decode_stage decode_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (front_hold),
        .bubble (load_stall),
        .flush  (flush),
        .if_id  (if_id),
        .wb     (mem_wb),
        .id_ex  (id_ex)
    );

    execute_stage execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (stall),
        .id_ex       (id_ex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .mem_fwd     (ex_mem),
        .wb_fwd      (mem_wb),
        .taken       (taken),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    memory_stage memory_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hold       (stall),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_we    (dmem_we),
        .mem_wb     (mem_wb)
    );

    hazard_unit hazard_i (
        .if_id      (if_id),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .taken      (taken),
        .dmem_ready (dmem_ready),
        .stall      (stall),
        .load_stall (load_stall),
        .flush      (flush),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam logic [31:0] reset_pc = 32'h0000_0000;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jump
    } br_op_e;

    typedef enum logic [1:0] {fwd_rf, fwd_mem, fwd_wb} fwd_sel_e;

    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_e;

    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e; // Matches funct3[1:0].

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        alu_op_e     alu_op;
        br_op_e      br_op;
        logic        use_imm;
        logic        use_pc_a;
        logic        is_jalr;
        logic        reg_we;
        logic        mem_re;
        logic        mem_we;
        mem_size_e   mem_size;
        logic        load_unsigned;
        wb_sel_e     wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic        reg_we;
        logic        mem_re;
        logic        mem_we;
        mem_size_e   mem_size;
        logic        load_unsigned;
        wb_sel_e     wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        reg_we;
        logic [31:0] wb_data;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== sim/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb;

    logic        clk, rst_n, dmem_ready, random_ready, halted, exp_halt;
    logic [31:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    logic [3:0]  dmem_be;
    logic        dmem_we, retire_valid;
    logic [31:0] retire_pc, retire_data, exp_pc, exp_data, m_pc, lfsr;
    logic [4:0]  retire_rd, exp_rd;
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:255];
    logic [31:0] m_mem [0:255];
    logic [31:0] m_regs [0:31];
    int          load_ptr;

    rv_core dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_be      (dmem_be),
        .dmem_we      (dmem_we),
        .dmem_rdata   (dmem_rdata),
        .dmem_ready   (dmem_ready),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #20 clk = ~clk;

    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_we && dmem_ready) begin
            for (int i = 0; i < 4; i++)
                if (dmem_be[i])
                    dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
        end
    end

    // Two bits per cycle, so memory is ready three times in four.
    always @(negedge clk) begin
        if (random_ready) begin
            lfsr       = lfsr_step(lfsr);
            dmem_ready = lfsr[0];
            lfsr       = lfsr_step(lfsr);
            dmem_ready = dmem_ready | lfsr[0];
        end else begin
            dmem_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && retire_valid) begin
            if (exp_halt)
                halted = 1'b1;
            model_step();
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) retire_valid |-> retire_pc == exp_pc)
        else mismatch("retire_pc", $sampled(retire_pc), $sampled(exp_pc));
    assert property (@(posedge clk) disable iff (!rst_n) retire_valid |-> retire_rd == exp_rd)
        else mismatch("retire_rd", $sampled(retire_rd), $sampled(exp_rd));
    assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && exp_rd != 5'd0 |-> retire_data == exp_data)
        else mismatch("retire_data", $sampled(retire_data), $sampled(exp_data));
    assert property (@(posedge clk) !rst_n |=> !retire_valid)
        else mismatch("retire_valid", $sampled(retire_valid), 32'd0);
    assert property (@(posedge clk) !rst_n |=> !dmem_we)
        else mismatch("dmem_we", $sampled(dmem_we), 32'd0);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, want));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'h9e3779b9 * (i + 1);
    endfunction

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, signed_less(a, b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return signed_less(a, b);
            3'd5:    return !signed_less(a, b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // One instruction of the ISA model; leaves the next retire prediction in exp_*.
    task automatic model_step();
        logic [31:0] ins, a, b, imm_i, imm_s, res, addr, word, npc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr;
        ins   = imem[m_pc[7:2]];
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        npc   = m_pc + 32'd4;
        wr    = 1'b1;
        res   = 32'd0;
        case (ins[6:0])
            7'h37: res = {ins[31:12], 12'd0};
            7'h17: res = m_pc + {ins[31:12], 12'd0};
            7'h6f: begin
                res = m_pc + 32'd4;
                npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                res = m_pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                if (branch_taken(f3, a, b))
                    npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h03: begin
                addr = a + imm_i;
                word = m_mem[addr[9:2]] >> (8 * addr[1:0]);
                case (f3[1:0])
                    2'd0:    res = {{24{word[7] & ~f3[2]}}, word[7:0]};
                    2'd1:    res = {{16{word[15] & ~f3[2]}}, word[15:0]};
                    default: res = word;
                endcase
            end
            7'h23: begin
                wr   = 1'b0;
                addr = a + imm_s;
                case (f3)
                    3'd0:    m_mem[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
                    3'd1:    m_mem[addr[9:2]][16*addr[1] +: 16] = b[15:0];
                    default: m_mem[addr[9:2]] = b;
                endcase
            end
            7'h13:   res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
            7'h33:   res = alu_ref(f3, ins[30], a, b);
            default: wr = 1'b0;
        endcase
        exp_pc   = m_pc;
        exp_rd   = wr ? rd : 5'd0;
        exp_data = res;
        exp_halt = (ins == 32'h0000_006f); // jal x0, 0.
        if (wr && rd != 5'd0)
            m_regs[rd] = res;
        m_pc = npc;
    endtask

    task automatic model_reset();
        m_pc   = 32'd0;
        halted = 1'b0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = 32'd0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]  <= fill_word(i);
            m_mem[i] = fill_word(i);
        end
        model_step();
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] ins);
        imem[load_ptr] = ins;
        load_ptr++;
    endtask

    task automatic wrong_path(input int n);
        emit(i_type(7'h13, 3'd0, 3, 0, n)); // Must never retire.
    endtask

    task automatic alu_mem_program();
        emit(u_type(7'h37, 1, 20'h12345));
        emit(i_type(7'h13, 3'd0, 1, 1, 12'h678));  // x1 from memory stage.
        emit(u_type(7'h17, 2, 20'h00001));
        emit(r_type(7'h00, 3'd0, 3, 1, 2));         // Both forward paths.
        emit(r_type(7'h20, 3'd0, 4, 3, 1));
        emit(i_type(7'h13, 3'd4, 5, 4, -1));
        emit(i_type(7'h13, 3'd1, 6, 5, 3));
        emit(i_type(7'h13, 3'd5, 7, 5, 12'h404));  // srai.
        emit(i_type(7'h13, 3'd5, 8, 5, 4));
        emit(r_type(7'h00, 3'd2, 9, 5, 1));
        emit(r_type(7'h00, 3'd3, 10, 5, 1));
        emit(r_type(7'h00, 3'd6, 11, 9, 10));
        emit(r_type(7'h00, 3'd7, 12, 3, 5));
        emit(r_type(7'h00, 3'd1, 13, 1, 11));
        emit(r_type(7'h20, 3'd5, 14, 5, 6));
        emit(r_type(7'h00, 3'd5, 15, 5, 6));
        emit(r_type(7'h00, 3'd4, 16, 13, 14));
        emit(i_type(7'h13, 3'd2, 17, 5, 0));
        emit(i_type(7'h13, 3'd3, 18, 17, 1));
        emit(i_type(7'h13, 3'd6, 19, 0, 12'h0f0));
        emit(i_type(7'h13, 3'd7, 20, 1, 12'h0ff));
        emit(i_type(7'h13, 3'd0, 21, 0, 12'h100)); // Data base.
        emit(s_type(3'd2, 21, 1, 0));
        emit(i_type(7'h13, 3'd0, 22, 0, -128));
        emit(s_type(3'd0, 21, 22, 4));
        emit(s_type(3'd0, 21, 1, 5));
        emit(s_type(3'd1, 21, 22, 6));             // Upper half.
        emit(s_type(3'd1, 21, 1, 8));
        emit(i_type(7'h03, 3'd0, 23, 21, 4));
        emit(i_type(7'h13, 3'd0, 24, 23, 1));      // Load-use.
        emit(i_type(7'h03, 3'd4, 25, 21, 4));
        emit(i_type(7'h03, 3'd1, 26, 21, 6));
        emit(i_type(7'h03, 3'd5, 27, 21, 6));
        emit(r_type(7'h00, 3'd0, 28, 27, 26));
        emit(i_type(7'h03, 3'd2, 29, 21, 0));
        emit(s_type(3'd2, 21, 29, 16));            // Load feeds store data.
        emit(i_type(7'h03, 3'd0, 30, 21, 5));
        emit(i_type(7'h03, 3'd5, 31, 21, 10));
        emit(i_type(7'h03, 3'd1, 31, 21, 2));
        emit(j_type(0, 0));
    endtask

    task automatic branch_program();
        emit(i_type(7'h13, 3'd0, 1, 0, 5));
        emit(i_type(7'h13, 3'd0, 2, 0, -3));
        emit(b_type(3'd0, 1, 1, 8));               // beq taken.
        wrong_path(1);
        emit(b_type(3'd1, 1, 1, 8));
        emit(b_type(3'd4, 2, 1, 8));               // blt taken.
        wrong_path(2);
        emit(b_type(3'd5, 2, 1, 8));
        emit(b_type(3'd6, 2, 1, 8));
        emit(b_type(3'd7, 2, 1, 8));               // bgeu taken.
        wrong_path(3);
        emit(j_type(4, 16));                       // To 60.
        emit(i_type(7'h13, 3'd0, 7, 0, 12'h100));  // jalr returns here.
        emit(j_type(0, 24));                       // To 76.
        wrong_path(4);
        emit(i_type(7'h67, 3'd0, 6, 4, 0));
        wrong_path(5);
        wrong_path(6);
        wrong_path(7);
        emit(i_type(7'h13, 3'd0, 8, 0, 4));
        emit(s_type(3'd2, 7, 8, 0));               // Loop body at 80.
        emit(i_type(7'h13, 3'd0, 7, 7, 4));
        emit(i_type(7'h13, 3'd0, 8, 8, -1));
        emit(b_type(3'd1, 8, 0, -12));
        emit(b_type(3'd5, 1, 2, 8));
        wrong_path(8);
        emit(b_type(3'd6, 1, 2, 8));
        wrong_path(9);
        emit(b_type(3'd4, 1, 2, 8));
        emit(i_type(7'h03, 3'd2, 9, 7, -4));
        emit(u_type(7'h17, 10, 0));
        emit(i_type(7'h67, 3'd0, 11, 10, 13));     // Odd target, bit 0 dropped.
        wrong_path(10);
        emit(j_type(0, 0));
    endtask

    task automatic run_program(input int prog, input logic rand_mode);
        int cycles;
        @(negedge clk);
        rst_n        = 1'b0;
        random_ready = rand_mode;
        for (int i = 0; i < 64; i++)
            imem[i] = 32'h0000_0013;
        load_ptr = 0;
        if (prog == 0)
            alu_mem_program();
        else
            branch_program();
        model_reset();
        repeat (5) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!halted && cycles < 3000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted)
            abort_run($sformatf("timeout: program %0d never retired its final self-jump", prog));
        for (int i = 0; i < 256; i++)
            assert (dmem[i] == m_mem[i])
                else mismatch($sformatf("dmem[%0d]", i), dmem[i], m_mem[i]);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        dmem_ready   = 1'b1;
        random_ready = 1'b0;
        halted       = 1'b0;
        exp_halt     = 1'b0;
        lfsr         = 32'ha72369af;
        for (int run = 0; run < 4; run++)
            run_program(run % 2, run >= 2); // Last two runs with random memory waits.
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/rv_pkg.sv
hdl/alu.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/rv_core.sv
sim/rv_core_tb.sv
